//--- ntt_add_sub_mod.sv
//====================================================================
// Modular adder / subtractor
//====================================================================
`timescale 1ns/1ps
`include "ntt_cfg.svh"

module ntt_add_sub_mod (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           sub_i,
    input  ntt_pkg::coef_t opa_i,
    input  ntt_pkg::coef_t opb_i,
    output ntt_pkg::coef_t res_o
);
    import ntt_pkg::*;

    localparam int         W     = `NTT_COEF_W;
    localparam logic [W:0] Q_EXT = (W+1)'(`NTT_Q);

    logic [W:0] raw;
    coef_t      res_next;

    // Operands are below q, so one correction step is enough
    always_comb begin
        if (sub_i) begin
            raw = {1'b0, opa_i} - {1'b0, opb_i};
            // Top bit set means a borrow, wrap back by adding q
            res_next = raw[W] ? W'(raw + Q_EXT) : raw[W-1:0];
        end else begin
            raw = {1'b0, opa_i} + {1'b0, opb_i};
            res_next = (raw >= Q_EXT) ? W'(raw - Q_EXT) : raw[W-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end else begin
            res_o <= res_next;
        end
    end

    res_below_q: assert property (@(posedge clk) disable iff (!reset_n)
        res_o < Q_EXT);

endmodule

//--- ntt_apb_regs.sv
//====================================================================
// APB register block
//====================================================================
`timescale 1ns/1ps
`include "ntt_cfg.svh"

module ntt_apb_regs (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  logic [4:0]       paddr_i,
    input  logic [31:0]      pwdata_i,
    output logic [31:0]      prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    output logic             bf_valid_o,
    output ntt_pkg::bf_in_t  bf_in_o,
    input  logic             bf_valid_i,
    input  ntt_pkg::bf_out_t bf_out_i
);
    import ntt_pkg::*;

    localparam int          W      = `NTT_COEF_W;
    localparam logic [31:0] Q_WORD = 32'(`NTT_Q);

    coef_t    op_u_q;
    coef_t    op_v_q;
    coef_t    op_w_q;
    bf_mode_e mode_q;
    coef_t    res_u_q;
    coef_t    res_v_q;
    logic     busy_q;
    logic     done_q;

    logic access;
    logic err;
    logic wr_ok;
    logic start;

    assign access = psel_i && penable_i;

    // Error decode for the access phase
    always_comb begin
        case (paddr_i)
            `NTT_REG_CTRL:
                err = pwrite_i && ((pwdata_i[2:0] > MODE_PWS) || (pwdata_i[8] && busy_q));
            `NTT_REG_OPU, `NTT_REG_OPV, `NTT_REG_OPW:
                err = pwrite_i && (pwdata_i >= Q_WORD);
            `NTT_REG_RES_U, `NTT_REG_RES_V, `NTT_REG_STATUS:
                err = pwrite_i;
            default:
                err = 1'b1;
        endcase
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = access && err;
    assign wr_ok     = access && pwrite_i && !err;
    assign start     = wr_ok && (paddr_i == `NTT_REG_CTRL) && pwdata_i[8];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_u_q     <= '0;
            op_v_q     <= '0;
            op_w_q     <= '0;
            mode_q     <= MODE_CT;
            res_u_q    <= '0;
            res_v_q    <= '0;
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            bf_valid_o <= 1'b0;
        end else begin
            bf_valid_o <= start;
            if (wr_ok) begin
                case (paddr_i)
                    `NTT_REG_CTRL: mode_q <= bf_mode_e'(pwdata_i[2:0]);
                    `NTT_REG_OPU:  op_u_q <= pwdata_i[W-1:0];
                    `NTT_REG_OPV:  op_v_q <= pwdata_i[W-1:0];
                    `NTT_REG_OPW:  op_w_q <= pwdata_i[W-1:0];
                    default: ;
                endcase
            end
            // Start and completion never coincide, start needs !busy
            if (start) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (bf_valid_i) begin
                busy_q  <= 1'b0;
                done_q  <= 1'b1;
                res_u_q <= bf_out_i.res_u;
                res_v_q <= bf_out_i.res_v;
            end
        end
    end

    always_comb begin
        case (paddr_i)
            `NTT_REG_CTRL:   prdata_o = {29'b0, mode_q};
            `NTT_REG_OPU:    prdata_o = 32'(op_u_q);
            `NTT_REG_OPV:    prdata_o = 32'(op_v_q);
            `NTT_REG_OPW:    prdata_o = 32'(op_w_q);
            `NTT_REG_RES_U:  prdata_o = 32'(res_u_q);
            `NTT_REG_RES_V:  prdata_o = 32'(res_v_q);
            `NTT_REG_STATUS: prdata_o = {30'b0, busy_q, done_q};
            default:         prdata_o = '0;
        endcase
    end

    assign bf_in_o = '{mode: mode_q, u: op_u_q, v: op_v_q, w: op_w_q};

    apb_setup_first: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(penable_i) |-> psel_i && $past(psel_i));

endmodule

//--- ntt_butterfly.sv
//====================================================================
// Combined NTT butterfly pipeline
//====================================================================
`timescale 1ns/1ps
`include "ntt_cfg.svh"

module ntt_butterfly (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             valid_i,
    input  ntt_pkg::bf_in_t  in_i,
    output logic             valid_o,
    output ntt_pkg::bf_out_t out_o
);
    import ntt_pkg::*;

    localparam int LAT = `NTT_BF_LATENCY;

    // Stage k of the pipe sits at index k-1
    logic [LAT-1:0] valid_q;
    bf_mode_e       mode_q [LAT];
    coef_t          u_q [3];
    coef_t          w_q [3];
    coef_t          early_q [3];

    logic  ct_late;
    logic  gs_mid;
    coef_t sum_res;
    coef_t diff_res;
    coef_t post_res;
    coef_t mult_res;
    coef_t diff_opa;
    coef_t diff_opb;
    coef_t mult_opa;
    coef_t mult_opb;
    coef_t post_opa;
    coef_t early;

    //====================================================================
    // Unit sharing
    //====================================================================
    // The difference unit serves GS/PWS in stage 0 and CT in stage 3,
    // the multiplier serves GS in stage 1 and the others in stage 0.
    // A stream of one mode never collides, mixed streams need gaps
    assign ct_late = valid_q[2] && (mode_q[2] == MODE_CT);
    assign gs_mid  = valid_q[0] && (mode_q[0] == MODE_GS);

    always_comb begin
        if (ct_late) begin
            diff_opa = u_q[2];
            diff_opb = mult_res;
        end else begin
            diff_opa = in_i.u;
            diff_opb = in_i.v;
        end
    end

    always_comb begin
        if (gs_mid) begin
            // (u - v) * w
            mult_opa = diff_res;
            mult_opb = w_q[0];
        end else if (in_i.mode == MODE_CT) begin
            mult_opa = in_i.v;
            mult_opb = in_i.w;
        end else begin
            mult_opa = in_i.u;
            mult_opb = in_i.v;
        end
    end

    // Post unit adds u, w or nothing to the product
    always_comb begin
        case (mode_q[2])
            MODE_CT:   post_opa = u_q[2];
            MODE_PWMA: post_opa = w_q[2];
            default:   post_opa = '0;
        endcase
    end

    assign early = (mode_q[0] == MODE_PWS) ? diff_res : sum_res;

    ntt_add_sub_mod sum_unit (
        .clk     (clk),
        .reset_n (reset_n),
        .sub_i   (1'b0),
        .opa_i   (in_i.u),
        .opb_i   (in_i.v),
        .res_o   (sum_res)
    );

    ntt_add_sub_mod diff_unit (
        .clk     (clk),
        .reset_n (reset_n),
        .sub_i   (1'b1),
        .opa_i   (diff_opa),
        .opb_i   (diff_opb),
        .res_o   (diff_res)
    );

    ntt_add_sub_mod post_unit (
        .clk     (clk),
        .reset_n (reset_n),
        .sub_i   (1'b0),
        .opa_i   (post_opa),
        .opb_i   (mult_res),
        .res_o   (post_res)
    );

    ntt_mult_mod mult_unit (
        .clk     (clk),
        .reset_n (reset_n),
        .opa_i   (mult_opa),
        .opb_i   (mult_opb),
        .res_o   (mult_res)
    );

    //====================================================================
    // Delay lines
    //====================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= '0;
            for (int i = 0; i < LAT; i++) begin
                mode_q[i] <= MODE_CT;
            end
            for (int i = 0; i < 3; i++) begin
                u_q[i]     <= '0;
                w_q[i]     <= '0;
                early_q[i] <= '0;
            end
        end else begin
            valid_q   <= {valid_q[LAT-2:0], valid_i};
            mode_q[0] <= in_i.mode;
            for (int i = 1; i < LAT; i++) begin
                mode_q[i] <= mode_q[i-1];
            end
            // u and w wait for the product, the early sum/diff for GS
            u_q[0]     <= in_i.u;
            w_q[0]     <= in_i.w;
            early_q[0] <= early;
            for (int i = 1; i < 3; i++) begin
                u_q[i]     <= u_q[i-1];
                w_q[i]     <= w_q[i-1];
                early_q[i] <= early_q[i-1];
            end
        end
    end

    // Result select by the mode that left with this item
    always_comb begin
        case (mode_q[LAT-1])
            MODE_CT: begin
                out_o.res_u = post_res;
                out_o.res_v = diff_res;
            end
            MODE_GS: begin
                out_o.res_u = early_q[2];
                out_o.res_v = mult_res;
            end
            MODE_PWM, MODE_PWMA: begin
                out_o.res_u = post_res;
                out_o.res_v = '0;
            end
            MODE_PWA, MODE_PWS: begin
                out_o.res_u = early_q[2];
                out_o.res_v = '0;
            end
            default: begin
                out_o.res_u = '0;
                out_o.res_v = '0;
            end
        endcase
    end

    assign valid_o = valid_q[LAT-1];

    // A new item must not need a unit that an older item still holds
    unit_clash: assert property (@(posedge clk) disable iff (!reset_n)
        valid_i |-> !(ct_late && (in_i.mode inside {MODE_GS, MODE_PWS}))
                 && !(gs_mid && (in_i.mode inside {MODE_CT, MODE_PWM, MODE_PWMA})));

endmodule

//--- ntt_cfg.svh
//====================================================================
// NTT accelerator constants
//====================================================================
`ifndef NTT_CFG_SVH
`define NTT_CFG_SVH

// ML-KEM prime and coefficient width
`define NTT_Q          3329
`define NTT_COEF_W     12

// floor(2^24 / q) for the Barrett quotient estimate
`define NTT_BARRETT_M  5039

// Butterfly latency in every mode
`define NTT_BF_LATENCY 4

// APB byte offsets
`define NTT_REG_CTRL   5'h00
`define NTT_REG_OPU    5'h04
`define NTT_REG_OPV    5'h08
`define NTT_REG_OPW    5'h0c
`define NTT_REG_RES_U  5'h10
`define NTT_REG_RES_V  5'h14
`define NTT_REG_STATUS 5'h18

`endif

//--- ntt_mult_mod.sv
//====================================================================
// Modular multiplier, Barrett reduction
//====================================================================
`timescale 1ns/1ps
`include "ntt_cfg.svh"

module ntt_mult_mod (
    input  logic           clk,
    input  logic           reset_n,
    input  ntt_pkg::coef_t opa_i,
    input  ntt_pkg::coef_t opb_i,
    output ntt_pkg::coef_t res_o
);
    import ntt_pkg::*;

    localparam int            W         = `NTT_COEF_W;
    localparam int            PW        = 2 * W;
    localparam int            MW        = $clog2(`NTT_BARRETT_M + 1);
    localparam logic [W:0]    Q_EXT     = (W+1)'(`NTT_Q);
    localparam logic [MW-1:0] BARRETT_M = MW'(`NTT_BARRETT_M);

    // Stage 1
    logic [PW-1:0]    prod_q;
    // Stage 2
    logic [PW+MW-1:0] prod_m;
    logic [W:0]       quot_q;
    logic [W:0]       prod_lo_q;
    // Stage 3
    logic [W:0]       rem;
    coef_t            res_next;

    // Quotient estimate is floor(x * m / 2^24), never above the true one
    assign prod_m = prod_q * BARRETT_M;

    // The remainder is below 2q and fits in W+1 bits,
    // so only the low bits of the product and of quot*q matter
    assign rem      = prod_lo_q - quot_q * Q_EXT;
    assign res_next = (rem >= Q_EXT) ? W'(rem - Q_EXT) : rem[W-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q    <= '0;
            quot_q    <= '0;
            prod_lo_q <= '0;
            res_o     <= '0;
        end else begin
            prod_q    <= opa_i * opb_i;
            quot_q    <= prod_m[PW +: W+1];
            prod_lo_q <= prod_q[W:0];
            res_o     <= res_next;
        end
    end

    prod_below_q: assert property (@(posedge clk) disable iff (!reset_n)
        res_o < Q_EXT);

endmodule

//--- ntt_pkg.sv
//====================================================================
// NTT accelerator types
//====================================================================
`include "ntt_cfg.svh"

package ntt_pkg;

    // One coefficient modulo q
    typedef logic [`NTT_COEF_W-1:0] coef_t;

    // Butterfly operation, codes 6 and 7 are illegal
    typedef enum logic [2:0] {
        MODE_CT   = 3'd0,
        MODE_GS   = 3'd1,
        MODE_PWM  = 3'd2,
        MODE_PWMA = 3'd3,
        MODE_PWA  = 3'd4,
        MODE_PWS  = 3'd5
    } bf_mode_e;

    // Operation issued to the butterfly
    typedef struct packed {
        bf_mode_e mode;
        coef_t    u;
        coef_t    v;
        coef_t    w;
    } bf_in_t;

    // Butterfly results
    typedef struct packed {
        coef_t res_u;
        coef_t res_v;
    } bf_out_t;

endpackage

//--- ntt_top.sv
//====================================================================
// NTT accelerator top level
//====================================================================
`timescale 1ns/1ps

module ntt_top (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [4:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o
);
    import ntt_pkg::*;

    logic    bf_valid;
    bf_in_t  bf_in;
    logic    out_valid;
    bf_out_t bf_out;

    ntt_apb_regs regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .bf_valid_o (bf_valid),
        .bf_in_o    (bf_in),
        .bf_valid_i (out_valid),
        .bf_out_i   (bf_out)
    );

    ntt_butterfly butterfly (
        .clk     (clk),
        .reset_n (reset_n),
        .valid_i (bf_valid),
        .in_i    (bf_in),
        .valid_o (out_valid),
        .out_o   (bf_out)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run the NTT accelerator testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ntt_top -f sources.f

# The log decides the verdict, so the run itself may exit non-zero
./obj_dir/Vtb_ntt_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation finished without failure"

//--- sources.f
+incdir+.
ntt_pkg.sv
ntt_add_sub_mod.sv
ntt_mult_mod.sv
ntt_butterfly.sv
ntt_apb_regs.sv
ntt_top.sv
tb_ntt_top.sv

//--- tb_ntt_top.sv
//====================================================================
// NTT accelerator testbench
//====================================================================
`timescale 1ns/1ps
`include "ntt_cfg.svh"

module tb_ntt_top;
    import ntt_pkg::*;

    localparam int Q = `NTT_Q;

    logic        clk;
    logic        reset_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    integer      seed;

    ntt_top uut (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #10 clk = ~clk;

    //====================================================================
    // Checking and reference model
    //====================================================================
    task automatic fail_stop;
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s, got %0d, expected %0d",
                     $time, msg, actual, expected);
            fail_stop();
        end
    endtask

    function automatic int mod_q(input int x);
        int r;
        r = x % Q;
        if (r < 0) begin
            r = r + Q;
        end
        return r;
    endfunction

    function automatic int rand_coef();
        int r;
        r = $random(seed);
        return mod_q(r);
    endfunction

    // Fermat inverse, w^(q-2) mod q
    function automatic int inv_mod(input int w);
        int result;
        int base;
        int e;
        result = 1;
        base = w;
        e = Q - 2;
        while (e > 0) begin
            if (e[0]) begin
                result = mod_q(result * base);
            end
            base = mod_q(base * base);
            e = e >> 1;
        end
        return result;
    endfunction

    task automatic model(input bf_mode_e mode, input int u, input int v, input int w,
                         output int ru, output int rv);
        rv = 0;
        case (mode)
            MODE_CT: begin
                ru = mod_q(u + v * w);
                rv = mod_q(u - v * w);
            end
            MODE_GS: begin
                ru = mod_q(u + v);
                rv = mod_q(mod_q(u - v) * w);
            end
            MODE_PWM:  ru = mod_q(u * v);
            MODE_PWMA: ru = mod_q(w + u * v);
            MODE_PWA:  ru = mod_q(u + v);
            default:   ru = mod_q(u - v);
        endcase
    endtask

    //====================================================================
    // APB access, entered and left on a falling edge
    //====================================================================
    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data,
                             output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        err = pslverr;
        check(32'(pready), 1, "PREADY low in write access");
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_done;
        logic [31:0] status;
        logic        err;
        int          polls;
        polls = 0;
        status = '0;
        while (status[0] !== 1'b1 && polls < 50) begin
            apb_read(`NTT_REG_STATUS, status, err);
            polls++;
        end
        if (status[0] !== 1'b1) begin
            $display("Timeout: done flag not set after 50 STATUS polls");
            fail_stop();
        end
    endtask

    task automatic read_expect(input logic [4:0] addr, input int expected, input string msg);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check(32'(err), 0, {msg, " read error"});
        check(data, 32'(expected), msg);
    endtask

    task automatic run_op(input bf_mode_e mode, input int u, input int v, input int w,
                          output int ru, output int rv);
        logic        err;
        logic [31:0] data;
        apb_write(`NTT_REG_OPU, 32'(u), err);
        check(32'(err), 0, "operand u rejected");
        apb_write(`NTT_REG_OPV, 32'(v), err);
        check(32'(err), 0, "operand v rejected");
        apb_write(`NTT_REG_OPW, 32'(w), err);
        check(32'(err), 0, "operand w rejected");
        apb_write(`NTT_REG_CTRL, 32'h100 | 32'(mode), err);
        check(32'(err), 0, "start rejected");
        wait_done();
        apb_read(`NTT_REG_RES_U, data, err);
        ru = int'(data);
        apb_read(`NTT_REG_RES_V, data, err);
        rv = int'(data);
    endtask

    task automatic check_op(input bf_mode_e mode, input int u, input int v, input int w);
        int    ru;
        int    rv;
        int    eu;
        int    ev;
        string tag;
        run_op(mode, u, v, w, ru, rv);
        model(mode, u, v, w, eu, ev);
        tag = $sformatf("%s u=%0d v=%0d w=%0d", mode.name(), u, v, w);
        check(32'(ru), 32'(eu), {tag, " result u"});
        check(32'(rv), 32'(ev), {tag, " result v"});
    endtask

    //====================================================================
    // Directed tests
    //====================================================================
    task automatic test_reset;
        read_expect(`NTT_REG_CTRL, 0, "CTRL after reset");
        read_expect(`NTT_REG_OPU, 0, "OPU after reset");
        read_expect(`NTT_REG_OPV, 0, "OPV after reset");
        read_expect(`NTT_REG_OPW, 0, "OPW after reset");
        read_expect(`NTT_REG_RES_U, 0, "RES_U after reset");
        read_expect(`NTT_REG_RES_V, 0, "RES_V after reset");
        read_expect(`NTT_REG_STATUS, 0, "STATUS after reset");
    endtask

    task automatic test_ct_gs;
        int edges[3];
        edges = '{0, 1, Q - 1};
        foreach (edges[a]) begin
            foreach (edges[b]) begin
                foreach (edges[c]) begin
                    check_op(MODE_CT, edges[a], edges[b], edges[c]);
                    check_op(MODE_GS, edges[a], edges[b], edges[c]);
                end
            end
        end
        for (int i = 0; i < 20; i++) begin
            check_op(MODE_CT, rand_coef(), rand_coef(), rand_coef());
            check_op(MODE_GS, rand_coef(), rand_coef(), rand_coef());
        end
    endtask

    task automatic test_pointwise;
        bf_mode_e modes[4];
        modes = '{MODE_PWM, MODE_PWMA, MODE_PWA, MODE_PWS};
        foreach (modes[m]) begin
            for (int i = 0; i < 10; i++) begin
                check_op(modes[m], rand_coef(), rand_coef(), rand_coef());
            end
        end
    endtask

    // Inverse twiddle in GS undoes the CT product
    task automatic test_round_trip;
        int u;
        int v;
        int w;
        int a;
        int b;
        int ru;
        int rv;
        for (int i = 0; i < 10; i++) begin
            u = rand_coef();
            v = rand_coef();
            w = 1 + mod_q(rand_coef()) % (Q - 1);
            run_op(MODE_CT, u, v, w, a, b);
            run_op(MODE_GS, a, b, inv_mod(w), ru, rv);
            check(32'(ru), 32'(mod_q(2 * u)), "round trip result u");
            check(32'(rv), 32'(mod_q(2 * v)), "round trip result v");
        end
    endtask

    task automatic test_errors;
        logic        err;
        logic [31:0] data;
        int          ru;
        int          rv;
        run_op(MODE_PWA, 5, 6, 7, ru, rv);
        apb_write(`NTT_REG_OPU, 32'(Q), err);
        check(32'(err), 1, "PSLVERR on operand equal to q");
        read_expect(`NTT_REG_OPU, 5, "OPU after rejected write");
        apb_write(`NTT_REG_OPV, 32'h0001_0000, err);
        check(32'(err), 1, "PSLVERR on large operand");
        read_expect(`NTT_REG_OPV, 6, "OPV after rejected write");
        apb_write(5'h1c, 32'd1, err);
        check(32'(err), 1, "PSLVERR on unmapped write");
        read_expect(`NTT_REG_OPW, 7, "OPW after unmapped write");
        apb_read(5'h1c, data, err);
        check(32'(err), 1, "PSLVERR on unmapped read");
        apb_write(`NTT_REG_RES_U, 32'd99, err);
        check(32'(err), 1, "PSLVERR on result write");
        read_expect(`NTT_REG_RES_U, 11, "RES_U after rejected write");
        apb_write(`NTT_REG_CTRL, 32'h106, err);
        check(32'(err), 1, "PSLVERR on illegal mode");
        read_expect(`NTT_REG_CTRL, int'(MODE_PWA), "CTRL after illegal mode");
        read_expect(`NTT_REG_STATUS, 1, "STATUS after illegal mode");
        // Second start right behind a legal one
        apb_write(`NTT_REG_OPU, 32'd20, err);
        apb_write(`NTT_REG_CTRL, 32'h100 | 32'(MODE_PWS), err);
        check(32'(err), 0, "legal start rejected");
        apb_write(`NTT_REG_CTRL, 32'h100 | 32'(MODE_CT), err);
        check(32'(err), 1, "PSLVERR on start while busy");
        wait_done();
        read_expect(`NTT_REG_CTRL, int'(MODE_PWS), "CTRL after start while busy");
        read_expect(`NTT_REG_RES_U, 14, "RES_U of the accepted start");
    endtask

    task automatic test_done_flag;
        logic err;
        int   ru;
        int   rv;
        run_op(MODE_PWM, rand_coef(), rand_coef(), 0, ru, rv);
        read_expect(`NTT_REG_STATUS, 1, "STATUS done after operation");
        apb_write(`NTT_REG_CTRL, 32'h100 | 32'(MODE_PWM), err);
        check(32'(err), 0, "restart rejected");
        read_expect(`NTT_REG_STATUS, 2, "STATUS busy after new start");
        wait_done();
        read_expect(`NTT_REG_STATUS, 1, "STATUS done again");
    endtask

    initial begin
        seed = 32'hc6ed_8c8a;
        clk = 1'b0;
        reset_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        test_reset();
        test_ct_gs();
        test_pointwise();
        test_round_trip();
        test_errors();
        test_done_flag();
        $display("Testbench passed");
        $finish;
    end

endmodule
